/* Makefile */
# Verilator simulation of the reservation station testbench

VERILATOR ?= verilator
TOP       ?= tb_rs_top
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0

SRCS    := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard hdl/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(BIN)

$(BIN): $(SRCS) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)

check: run
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "No result found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* build.f */
+incdir+hdl
hdl/rs_pkg.sv
hdl/rs_if.sv
hdl/rs_dispatch.sv
hdl/rs_station.sv
hdl/rs_top.sv
test/tb_rs_top.sv

/* hdl/rs_consts.svh */
`ifndef RS_CONSTS_SVH
`define RS_CONSTS_SVH

// Datapath widths
`define GPR_SIZE      64
`define ROB_IDX_SIZE  4
`define NZCV_SIZE     4
`define FU_OP_SIZE    4

// Entries per reservation station
`define RS_DEPTH      4

// Operation codes
`define FU_OP_ADD     4'd0
`define FU_OP_SUB     4'd1
`define FU_OP_AND     4'd2
`define FU_OP_ORR     4'd3
`define FU_OP_CMP     4'd4
`define FU_OP_LDUR    4'd5
`define FU_OP_STUR    4'd6

`endif

/* hdl/rs_dispatch.sv */
`timescale 1ns/1ps

module rs_dispatch (
  input  logic             in_clk,
  input  logic             in_rst_n,
  input  logic             in_disp_valid,
  output logic             out_disp_ready,
  input  rs_pkg::fu_op_t   in_disp_op,
  input  logic             in_disp_a_valid,
  input  rs_pkg::gpr_t     in_disp_a_value,
  input  rs_pkg::rob_tag_t in_disp_a_tag,
  input  logic             in_disp_b_valid,
  input  rs_pkg::gpr_t     in_disp_b_value,
  input  rs_pkg::rob_tag_t in_disp_b_tag,
  input  logic             in_disp_uses_nzcv,
  input  logic             in_disp_nzcv_valid,
  input  rs_pkg::nzcv_t    in_disp_nzcv,
  input  rs_pkg::rob_tag_t in_disp_nzcv_tag,
  input  logic             in_disp_set_nzcv,
  input  rs_pkg::rob_tag_t in_disp_dst_tag,
  rs_bcast_if.sink         bcast,
  rs_alloc_if.router       alu_alloc,
  rs_alloc_if.router       ls_alloc
);
  import rs_pkg::*;

  logic  is_mem;
  logic  accept;
  logic  stall;
  logic  bc_a;
  logic  bc_b;
  logic  bc_f;
  logic  a_valid;
  gpr_t  a_value;
  logic  b_valid;
  gpr_t  b_value;
  logic  f_valid;
  nzcv_t f_value;
  // Results caught while the ROB holds a stalled dispatch
  logic  hold_a_valid;
  gpr_t  hold_a_value;
  logic  hold_b_valid;
  gpr_t  hold_b_value;
  logic  hold_f_valid;
  nzcv_t hold_f_value;

  assign is_mem         = is_mem_op(in_disp_op);
  assign out_disp_ready = is_mem ? ~ls_alloc.full : ~alu_alloc.full;
  assign accept         = in_disp_valid & out_disp_ready;
  assign stall          = in_disp_valid & ~out_disp_ready;

  // Same-cycle broadcast hits on operands still waiting
  assign bc_a = bcast.valid & ~in_disp_a_valid & ~hold_a_valid & (bcast.tag == in_disp_a_tag);
  assign bc_b = bcast.valid & ~in_disp_b_valid & ~hold_b_valid & (bcast.tag == in_disp_b_tag);
  assign bc_f = bcast.valid & bcast.set_nzcv & ~in_disp_nzcv_valid & ~hold_f_valid &
                (bcast.tag == in_disp_nzcv_tag);

  always_comb begin
    a_valid = in_disp_a_valid | hold_a_valid | bc_a;
    b_valid = in_disp_b_valid | hold_b_valid | bc_b;
    f_valid = in_disp_nzcv_valid | hold_f_valid | bc_f;
    a_value = in_disp_a_value;
    b_value = in_disp_b_value;
    f_value = in_disp_nzcv;
    if (hold_a_valid) begin
      a_value = hold_a_value;
    end else if (bc_a) begin
      // Memory ops carry the offset in A until the base arrives
      a_value = is_mem ? in_disp_a_value + bcast.value : bcast.value;
    end
    if (hold_b_valid) begin
      b_value = hold_b_value;
    end else if (bc_b) begin
      b_value = bcast.value;
    end
    if (hold_f_valid) begin
      f_value = hold_f_value;
    end else if (bc_f) begin
      f_value = bcast.nzcv;
    end
  end

  always_ff @(posedge in_clk or negedge in_rst_n) begin
    if (!in_rst_n) begin
      hold_a_valid <= 1'b0;
      hold_b_valid <= 1'b0;
      hold_f_valid <= 1'b0;
    end else begin
      hold_a_valid <= stall & (hold_a_valid | bc_a);
      hold_b_valid <= stall & (hold_b_valid | bc_b);
      hold_f_valid <= stall & (hold_f_valid | bc_f);
    end
  end

  always_ff @(posedge in_clk) begin
    if (bc_a) hold_a_value <= a_value;
    if (bc_b) hold_b_value <= b_value;
    if (bc_f) hold_f_value <= f_value;
  end

  // Only the target station sees valid
  assign alu_alloc.valid      = accept & ~is_mem;
  assign alu_alloc.op         = in_disp_op;
  assign alu_alloc.a_valid    = a_valid;
  assign alu_alloc.a_value    = a_value;
  assign alu_alloc.a_tag      = in_disp_a_tag;
  assign alu_alloc.b_valid    = b_valid;
  assign alu_alloc.b_value    = b_value;
  assign alu_alloc.b_tag      = in_disp_b_tag;
  assign alu_alloc.uses_nzcv  = in_disp_uses_nzcv;
  assign alu_alloc.nzcv_valid = f_valid;
  assign alu_alloc.nzcv       = f_value;
  assign alu_alloc.nzcv_tag   = in_disp_nzcv_tag;
  assign alu_alloc.set_nzcv   = in_disp_set_nzcv;
  assign alu_alloc.dst_tag    = in_disp_dst_tag;

  assign ls_alloc.valid       = accept & is_mem;
  assign ls_alloc.op          = in_disp_op;
  assign ls_alloc.a_valid     = a_valid;
  assign ls_alloc.a_value     = a_value;
  assign ls_alloc.a_tag       = in_disp_a_tag;
  assign ls_alloc.b_valid     = b_valid;
  assign ls_alloc.b_value     = b_value;
  assign ls_alloc.b_tag       = in_disp_b_tag;
  assign ls_alloc.uses_nzcv   = in_disp_uses_nzcv;
  assign ls_alloc.nzcv_valid  = f_valid;
  assign ls_alloc.nzcv        = f_value;
  assign ls_alloc.nzcv_tag    = in_disp_nzcv_tag;
  assign ls_alloc.set_nzcv    = in_disp_set_nzcv;
  assign ls_alloc.dst_tag     = in_disp_dst_tag;

endmodule

/* hdl/rs_if.sv */
`timescale 1ns/1ps

// Dispatch router to one reservation station
interface rs_alloc_if;
  import rs_pkg::*;

  logic     valid;
  fu_op_t   op;
  logic     a_valid;
  gpr_t     a_value;
  rob_tag_t a_tag;
  logic     b_valid;
  gpr_t     b_value;
  rob_tag_t b_tag;
  logic     uses_nzcv;
  logic     nzcv_valid;
  nzcv_t    nzcv;
  rob_tag_t nzcv_tag;
  logic     set_nzcv;
  rob_tag_t dst_tag;
  logic     full;

  modport router (
    output valid, op, a_valid, a_value, a_tag, b_valid, b_value, b_tag,
    output uses_nzcv, nzcv_valid, nzcv, nzcv_tag, set_nzcv, dst_tag,
    input  full
  );
  modport station (
    input  valid, op, a_valid, a_value, a_tag, b_valid, b_value, b_tag,
    input  uses_nzcv, nzcv_valid, nzcv, nzcv_tag, set_nzcv, dst_tag,
    output full
  );
endinterface

// Station to functional unit, start/ready handshake
interface rs_issue_if;
  import rs_pkg::*;

  logic     fu_ready;
  logic     start;
  fu_op_t   op;
  gpr_t     val_a;
  gpr_t     val_b;
  rob_tag_t dst_tag;
  logic     set_nzcv;
  nzcv_t    nzcv;

  modport station (input fu_ready, output start, op, val_a, val_b, dst_tag, set_nzcv, nzcv);
  modport unit (output fu_ready, input start, op, val_a, val_b, dst_tag, set_nzcv, nzcv);
endinterface

// Common result broadcast
interface rs_bcast_if;
  import rs_pkg::*;

  logic     valid;
  rob_tag_t tag;
  gpr_t     value;
  logic     set_nzcv;
  nzcv_t    nzcv;

  modport source (output valid, tag, value, set_nzcv, nzcv);
  modport sink (input valid, tag, value, set_nzcv, nzcv);
endinterface

/* hdl/rs_pkg.sv */
`include "rs_consts.svh"

package rs_pkg;

  // Register value, also the broadcast result
  typedef logic [`GPR_SIZE-1:0] gpr_t;

  // ROB entry index naming a producer
  typedef logic [`ROB_IDX_SIZE-1:0] rob_tag_t;

  // Condition flags
  typedef logic [`NZCV_SIZE-1:0] nzcv_t;

  typedef logic [`FU_OP_SIZE-1:0] fu_op_t;

  // Loads and stores belong to the load/store unit
  function automatic logic is_mem_op(input fu_op_t op);
    return (op == `FU_OP_LDUR) || (op == `FU_OP_STUR);
  endfunction

endpackage

/* hdl/rs_station.sv */
`timescale 1ns/1ps
`include "rs_consts.svh"

module rs_station #(
  parameter int DEPTH = `RS_DEPTH
) (
  input  logic        in_clk,
  input  logic        in_rst_n,
  input  logic        in_flush,
  rs_alloc_if.station alloc,
  rs_bcast_if.sink    bcast,
  rs_issue_if.station issue
);
  import rs_pkg::*;

  localparam int IDX_W = $clog2(DEPTH);

  // Entry status bits
  logic [DEPTH-1:0] ent_valid;
  logic [DEPTH-1:0] a_valid;
  logic [DEPTH-1:0] b_valid;
  logic [DEPTH-1:0] f_valid;
  logic [DEPTH-1:0] uses_f;
  logic [DEPTH-1:0] set_f;
  logic [DEPTH-1:0] rdy;

  // Entry payload
  fu_op_t   op_q  [DEPTH];
  gpr_t     a_val [DEPTH];
  rob_tag_t a_tag [DEPTH];
  gpr_t     b_val [DEPTH];
  rob_tag_t b_tag [DEPTH];
  nzcv_t    f_val [DEPTH];
  rob_tag_t f_tag [DEPTH];
  rob_tag_t dst_q [DEPTH];

  logic [IDX_W-1:0] free_idx;
  logic             free_found;
  logic [IDX_W-1:0] sel_idx;
  logic             sel_found;
  logic             alloc_we;
  logic             issue_go;

  // Ready once both operands and any needed flags are in
  always_comb begin
    for (int i = 0; i < DEPTH; i++) begin
      rdy[i] = ent_valid[i] & a_valid[i] & b_valid[i] & (~uses_f[i] | f_valid[i]);
    end
  end

  // Lowest free slot and lowest ready slot
  always_comb begin
    free_idx   = '0;
    free_found = 1'b0;
    sel_idx    = '0;
    sel_found  = 1'b0;
    for (int i = DEPTH - 1; i >= 0; i--) begin
      if (!ent_valid[i]) begin
        free_idx   = IDX_W'(i);
        free_found = 1'b1;
      end
      if (rdy[i]) begin
        sel_idx   = IDX_W'(i);
        sel_found = 1'b1;
      end
    end
  end

  assign alloc.full = ~free_found;
  assign alloc_we   = alloc.valid & free_found;
  assign issue_go   = issue.fu_ready & sel_found;

  // Occupancy, a flush also drops a same-cycle write
  always_ff @(posedge in_clk or negedge in_rst_n) begin
    if (!in_rst_n) begin
      ent_valid <= '0;
    end else if (in_flush) begin
      ent_valid <= '0;
    end else begin
      if (issue_go) begin
        ent_valid[sel_idx] <= 1'b0;
      end
      if (alloc_we) begin
        ent_valid[free_idx] <= 1'b1;
      end
    end
  end

  // Entry write and broadcast wakeup
  always_ff @(posedge in_clk) begin
    for (int i = 0; i < DEPTH; i++) begin
      if (alloc_we && free_idx == IDX_W'(i)) begin
        op_q[i]    <= alloc.op;
        a_valid[i] <= alloc.a_valid;
        a_val[i]   <= alloc.a_value;
        a_tag[i]   <= alloc.a_tag;
        b_valid[i] <= alloc.b_valid;
        b_val[i]   <= alloc.b_value;
        b_tag[i]   <= alloc.b_tag;
        uses_f[i]  <= alloc.uses_nzcv;
        f_valid[i] <= alloc.nzcv_valid;
        f_val[i]   <= alloc.nzcv;
        f_tag[i]   <= alloc.nzcv_tag;
        set_f[i]   <= alloc.set_nzcv;
        dst_q[i]   <= alloc.dst_tag;
      end else if (ent_valid[i] && bcast.valid) begin
        if (!a_valid[i] && a_tag[i] == bcast.tag) begin
          a_valid[i] <= 1'b1;
          // Base plus stored offset forms the address
          a_val[i]   <= is_mem_op(op_q[i]) ? a_val[i] + bcast.value : bcast.value;
        end
        if (!b_valid[i] && b_tag[i] == bcast.tag) begin
          b_valid[i] <= 1'b1;
          b_val[i]   <= bcast.value;
        end
        if (bcast.set_nzcv && !f_valid[i] && f_tag[i] == bcast.tag) begin
          f_valid[i] <= 1'b1;
          f_val[i]   <= bcast.nzcv;
        end
      end
    end
  end

  // Payload of the selected entry goes straight to the unit
  assign issue.start    = issue_go;
  assign issue.op       = op_q[sel_idx];
  assign issue.val_a    = a_val[sel_idx];
  assign issue.val_b    = b_val[sel_idx];
  assign issue.dst_tag  = dst_q[sel_idx];
  assign issue.set_nzcv = set_f[sel_idx];
  assign issue.nzcv     = f_val[sel_idx];

endmodule

/* hdl/rs_top.sv */
`timescale 1ns/1ps
`include "rs_consts.svh"

module rs_top (
  input  logic             in_clk,
  input  logic             in_rst_n,
  // Dispatch from the ROB
  input  logic             in_disp_valid,
  input  rs_pkg::fu_op_t   in_disp_op,
  input  logic             in_disp_a_valid,
  input  rs_pkg::gpr_t     in_disp_a_value,
  input  rs_pkg::rob_tag_t in_disp_a_tag,
  input  logic             in_disp_b_valid,
  input  rs_pkg::gpr_t     in_disp_b_value,
  input  rs_pkg::rob_tag_t in_disp_b_tag,
  input  logic             in_disp_uses_nzcv,
  input  logic             in_disp_nzcv_valid,
  input  rs_pkg::nzcv_t    in_disp_nzcv,
  input  rs_pkg::rob_tag_t in_disp_nzcv_tag,
  input  logic             in_disp_set_nzcv,
  input  rs_pkg::rob_tag_t in_disp_dst_tag,
  output logic             out_disp_ready,
  // Result broadcast
  input  logic             in_bc_valid,
  input  rs_pkg::rob_tag_t in_bc_tag,
  input  rs_pkg::gpr_t     in_bc_value,
  input  logic             in_bc_set_nzcv,
  input  rs_pkg::nzcv_t    in_bc_nzcv,
  input  logic             in_mispred,
  // ALU
  input  logic             in_alu_ready,
  output logic             out_alu_start,
  output rs_pkg::fu_op_t   out_alu_op,
  output rs_pkg::gpr_t     out_alu_val_a,
  output rs_pkg::gpr_t     out_alu_val_b,
  output rs_pkg::rob_tag_t out_alu_dst_tag,
  output logic             out_alu_set_nzcv,
  output rs_pkg::nzcv_t    out_alu_nzcv,
  // Load/store unit
  input  logic             in_ls_ready,
  output logic             out_ls_start,
  output rs_pkg::fu_op_t   out_ls_op,
  output rs_pkg::gpr_t     out_ls_val_a,
  output rs_pkg::gpr_t     out_ls_val_b,
  output rs_pkg::rob_tag_t out_ls_dst_tag
);

  rs_alloc_if alu_alloc ();
  rs_alloc_if ls_alloc ();
  rs_issue_if alu_issue ();
  rs_issue_if ls_issue ();
  rs_bcast_if bcast ();

  assign bcast.valid    = in_bc_valid;
  assign bcast.tag      = in_bc_tag;
  assign bcast.value    = in_bc_value;
  assign bcast.set_nzcv = in_bc_set_nzcv;
  assign bcast.nzcv     = in_bc_nzcv;

  // Dispatch ports share their names with the router
  rs_dispatch i_dispatch (.*);

  rs_station #(
    .DEPTH(`RS_DEPTH)
  ) i_alu_rs (
    .in_clk  (in_clk),
    .in_rst_n(in_rst_n),
    .in_flush(in_mispred),
    .alloc   (alu_alloc),
    .bcast   (bcast),
    .issue   (alu_issue)
  );

  rs_station #(
    .DEPTH(`RS_DEPTH)
  ) i_ls_rs (
    .in_clk  (in_clk),
    .in_rst_n(in_rst_n),
    .in_flush(in_mispred),
    .alloc   (ls_alloc),
    .bcast   (bcast),
    .issue   (ls_issue)
  );

  assign alu_issue.fu_ready = in_alu_ready;
  assign out_alu_start      = alu_issue.start;
  assign out_alu_op         = alu_issue.op;
  assign out_alu_val_a      = alu_issue.val_a;
  assign out_alu_val_b      = alu_issue.val_b;
  assign out_alu_dst_tag    = alu_issue.dst_tag;
  assign out_alu_set_nzcv   = alu_issue.set_nzcv;
  assign out_alu_nzcv       = alu_issue.nzcv;

  // Flags stay inside the load/store path
  assign ls_issue.fu_ready  = in_ls_ready;
  assign out_ls_start       = ls_issue.start;
  assign out_ls_op          = ls_issue.op;
  assign out_ls_val_a       = ls_issue.val_a;
  assign out_ls_val_b       = ls_issue.val_b;
  assign out_ls_dst_tag     = ls_issue.dst_tag;

endmodule

/* test/rs_cases.txt */
# D op a_valid a_value a_tag b_valid b_value b_tag uses_nzcv nzcv_valid nzcv nzcv_tag set_nzcv dst
# E unit op val_a val_b dst nzcv max_wait | B valid tag value set_nzcv nzcv | P op ready
# U alu_ready ls_ready | I cycles | N quiet_cycles | F flush | T name | Q end, values in hex
T ready_issue
U 1 1
D 0 1 11 0 1 22 0 0 0 0 0 0 1
E alu 0 11 22 1 0 0
D 5 1 1000 0 1 0 0 0 0 0 0 0 2
E ls 5 1000 0 2 0 0
T tag_wakeup
D 1 0 0 3 1 5 0 0 0 0 0 0 4
N 2
# Other tag first, entry keeps waiting
B 1 2 77 0 0
I 1
N 1
B 1 3 100 0 0
I 1
E alu 1 100 5 4 0 0
# Load offset 10 plus base 2000
D 5 0 10 5 1 0 0 0 0 0 0 0 6
N 1
B 1 5 2000 0 0
I 1
E ls 5 2010 0 6 0 0
# Base arrives in the dispatch cycle
B 1 7 3000 0 0
D 5 0 8 7 1 0 0 0 0 0 0 0 8
E ls 5 3008 0 8 0 0
T flag_wait
D 0 1 1 0 1 2 0 1 0 0 9 0 a
N 1
B 1 9 55 0 0
I 1
N 2
B 1 9 55 1 6
I 1
E alu 0 1 2 a 6 0
T full_station
U 0 1
D 0 1 b1 0 1 b2 0 0 0 0 0 0 b
D 2 1 c1 0 1 c2 0 0 0 0 0 0 c
D 3 1 d1 0 1 d2 0 0 0 0 0 0 d
D 4 1 e1 0 1 e2 0 0 0 0 0 1 e
P 0 0
P 5 1
D 6 1 4000 0 1 beef 0 0 0 0 0 0 f
E ls 6 4000 beef f 0 0
U 1 1
E alu 0 b1 b2 b 0 0
E alu 2 c1 c2 c 0 0
# Slots 0 and 1 are free again
U 0 1
D 1 1 51 0 1 52 0 0 0 0 0 0 5
D 3 1 61 0 1 62 0 0 0 0 0 0 6
P 0 0
U 1 1
E alu 1 51 52 5 0 0
E alu 3 61 62 6 0 0
E alu 3 d1 d2 d 0 0
E alu 4 e1 e2 e 0 0
T flush
U 0 0
D 0 1 7 0 1 8 0 0 0 0 0 0 1
D 5 1 5000 0 1 0 0 0 0 0 0 0 2
D 2 0 0 c 1 9 0 0 0 0 0 0 3
F
U 1 1
N 3
P 0 1
P 5 1
B 1 c 99 0 0
I 1
N 2
D 3 1 30 0 1 3 0 0 0 0 0 0 7
E alu 3 30 3 7 0 0
Q

/* test/tb_rs_top.sv */
`timescale 1ns/1ps

module tb_rs_top;
  import rs_pkg::*;

  localparam int DISPATCH_LIMIT = 50;
  localparam int TAG_COUNT      = 1 << $bits(rob_tag_t);

  logic     in_clk;
  logic     in_rst_n;
  logic     in_disp_valid;
  fu_op_t   in_disp_op;
  logic     in_disp_a_valid;
  gpr_t     in_disp_a_value;
  rob_tag_t in_disp_a_tag;
  logic     in_disp_b_valid;
  gpr_t     in_disp_b_value;
  rob_tag_t in_disp_b_tag;
  logic     in_disp_uses_nzcv;
  logic     in_disp_nzcv_valid;
  nzcv_t    in_disp_nzcv;
  rob_tag_t in_disp_nzcv_tag;
  logic     in_disp_set_nzcv;
  rob_tag_t in_disp_dst_tag;
  logic     out_disp_ready;
  logic     in_bc_valid;
  rob_tag_t in_bc_tag;
  gpr_t     in_bc_value;
  logic     in_bc_set_nzcv;
  nzcv_t    in_bc_nzcv;
  logic     in_mispred;
  logic     in_alu_ready;
  logic     out_alu_start;
  fu_op_t   out_alu_op;
  gpr_t     out_alu_val_a;
  gpr_t     out_alu_val_b;
  rob_tag_t out_alu_dst_tag;
  logic     out_alu_set_nzcv;
  nzcv_t    out_alu_nzcv;
  logic     in_ls_ready;
  logic     out_ls_start;
  fu_op_t   out_ls_op;
  gpr_t     out_ls_val_a;
  gpr_t     out_ls_val_b;
  rob_tag_t out_ls_dst_tag;

  int    error_count;
  int    check_count;
  int    test_count;
  int    test_fail_count;
  int    test_errors;
  bit    test_open;
  bit    cases_done;
  string test_name;
  int    fd;
  // set_nzcv of each accepted instruction, by destination tag
  logic  sent_set_nzcv [TAG_COUNT];

  rs_top i_dut (.*);

  initial in_clk = 1'b0;
  always #4 in_clk = ~in_clk;

  // One clock edge, inputs change 1 ns after it
  task automatic advance();
    @(posedge in_clk);
    #1;
    in_bc_valid = 1'b0;
    in_mispred  = 1'b0;
  endtask

  task automatic note_error(input string msg);
    $display("error in %s: %s", test_name, msg);
    error_count++;
    test_errors++;
  endtask

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    check_count++;
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
      error_count++;
      test_errors++;
    end
  endtask

  task automatic finish_test();
    if (test_open) begin
      test_count++;
      if (test_errors == 0) begin
        $display("test %s: ok", test_name);
      end else begin
        test_fail_count++;
        $display("test %s: failed with %0d errors", test_name, test_errors);
      end
      test_open = 1'b0;
    end
  endtask

  // Hold the instruction until the router takes it
  task automatic dispatch(input string line);
    string    dummy;
    fu_op_t   op;
    logic     av;
    logic     bv;
    logic     un;
    logic     nv;
    logic     sn;
    gpr_t     aval;
    gpr_t     bval;
    rob_tag_t atag;
    rob_tag_t btag;
    rob_tag_t ntag;
    rob_tag_t dst;
    nzcv_t    nz;
    int       n;
    int       waited;
    logic     taken;
    n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h", dummy, op, av, aval,
                atag, bv, bval, btag, un, nv, nz, ntag, sn, dst);
    if (n != 14) begin
      note_error({"malformed dispatch line: ", line});
      return;
    end
    in_disp_op         = op;
    in_disp_a_valid    = av;
    in_disp_a_value    = aval;
    in_disp_a_tag      = atag;
    in_disp_b_valid    = bv;
    in_disp_b_value    = bval;
    in_disp_b_tag      = btag;
    in_disp_uses_nzcv  = un;
    in_disp_nzcv_valid = nv;
    in_disp_nzcv       = nz;
    in_disp_nzcv_tag   = ntag;
    in_disp_set_nzcv   = sn;
    in_disp_dst_tag    = dst;
    in_disp_valid      = 1'b1;
    waited = 0;
    taken  = 1'b0;
    while (!taken && waited < DISPATCH_LIMIT) begin
      @(negedge in_clk);
      taken = out_disp_ready;
      advance();
      waited++;
    end
    in_disp_valid = 1'b0;
    if (!taken) begin
      note_error($sformatf("dispatch was not accepted within %0d cycles", DISPATCH_LIMIT));
    end else begin
      sent_set_nzcv[dst] = sn;
    end
  endtask

  // Wait up to max_wait extra cycles for a start on the named unit
  task automatic expect_issue(input string line);
    string    dummy;
    string    unit;
    fu_op_t   op;
    gpr_t     a;
    gpr_t     b;
    rob_tag_t dst;
    nzcv_t    flags;
    int       max_wait;
    int       waited;
    int       n;
    logic     seen;
    n = $sscanf(line, "%s %s %h %h %h %h %h %d", dummy, unit, op, a, b, dst, flags, max_wait);
    if (n != 8 || (unit != "alu" && unit != "ls")) begin
      note_error({"malformed expectation line: ", line});
      return;
    end
    waited = 0;
    seen   = 1'b0;
    while (!seen && waited <= max_wait) begin
      @(negedge in_clk);
      if (unit == "alu" && out_alu_start) begin
        seen = 1'b1;
        compare_value("out_alu_op", 64'(out_alu_op), 64'(op));
        compare_value("out_alu_val_a", out_alu_val_a, a);
        compare_value("out_alu_val_b", out_alu_val_b, b);
        compare_value("out_alu_dst_tag", 64'(out_alu_dst_tag), 64'(dst));
        compare_value("out_alu_set_nzcv", 64'(out_alu_set_nzcv), 64'(sent_set_nzcv[dst]));
        compare_value("out_alu_nzcv", 64'(out_alu_nzcv), 64'(flags));
      end else if (unit == "ls" && out_ls_start) begin
        seen = 1'b1;
        compare_value("out_ls_op", 64'(out_ls_op), 64'(op));
        compare_value("out_ls_val_a", out_ls_val_a, a);
        compare_value("out_ls_val_b", out_ls_val_b, b);
        compare_value("out_ls_dst_tag", 64'(out_ls_dst_tag), 64'(dst));
      end
      advance();
      waited++;
    end
    if (!seen) begin
      note_error($sformatf("%s start did not come within %0d cycles", unit, max_wait + 1));
    end
  endtask

  task automatic expect_quiet(input int cycles);
    repeat (cycles) begin
      @(negedge in_clk);
      compare_value("out_alu_start", 64'(out_alu_start), 64'd0);
      compare_value("out_ls_start", 64'(out_ls_start), 64'd0);
      advance();
    end
  endtask

  // Ready depends on the station that the op would go to
  task automatic check_ready(input fu_op_t op, input logic exp);
    in_disp_op = op;
    @(negedge in_clk);
    compare_value("out_disp_ready", 64'(out_disp_ready), 64'(exp));
    advance();
  endtask

  task automatic run_cases();
    string    line;
    string    cmd;
    string    name;
    fu_op_t   op;
    logic     flag_a;
    logic     flag_b;
    rob_tag_t tag;
    gpr_t     value;
    nzcv_t    nz;
    int       count;
    int       cycles;
    while (!cases_done && !$feof(fd)) begin
      if ($fgets(line, fd) == 0) continue;
      if ($sscanf(line, "%s", cmd) != 1) continue;
      if (cmd.getc(0) == "#") continue;
      if (cmd == "T") begin
        finish_test();
        count       = $sscanf(line, "%s %s", cmd, name);
        test_name   = name;
        test_errors = 0;
        test_open   = 1'b1;
      end else if (cmd == "D") begin
        dispatch(line);
      end else if (cmd == "E") begin
        expect_issue(line);
      end else if (cmd == "B") begin
        count = $sscanf(line, "%s %h %h %h %h %h", cmd, flag_a, tag, value, flag_b, nz);
        if (count != 6) begin
          note_error({"malformed broadcast line: ", line});
        end else begin
          in_bc_valid    = flag_a;
          in_bc_tag      = tag;
          in_bc_value    = value;
          in_bc_set_nzcv = flag_b;
          in_bc_nzcv     = nz;
        end
      end else if (cmd == "U") begin
        count = $sscanf(line, "%s %h %h", cmd, flag_a, flag_b);
        if (count != 3) begin
          note_error({"malformed unit ready line: ", line});
        end else begin
          in_alu_ready = flag_a;
          in_ls_ready  = flag_b;
        end
      end else if (cmd == "P") begin
        count = $sscanf(line, "%s %h %h", cmd, op, flag_a);
        if (count != 3) begin
          note_error({"malformed ready check line: ", line});
        end else begin
          check_ready(op, flag_a);
        end
      end else if (cmd == "I") begin
        count = $sscanf(line, "%s %d", cmd, cycles);
        if (count != 2) begin
          note_error({"malformed idle line: ", line});
        end else begin
          repeat (cycles) advance();
        end
      end else if (cmd == "N") begin
        count = $sscanf(line, "%s %d", cmd, cycles);
        if (count != 2) begin
          note_error({"malformed quiet line: ", line});
        end else begin
          expect_quiet(cycles);
        end
      end else if (cmd == "F") begin
        in_mispred = 1'b1;
        advance();
      end else if (cmd == "Q") begin
        finish_test();
        cases_done = 1'b1;
      end else begin
        note_error({"unknown command in case file: ", line});
      end
    end
    if (!cases_done) begin
      note_error("case file ended without an end command");
      finish_test();
    end
  endtask

  initial begin
    in_rst_n           = 1'b0;
    in_disp_valid      = 1'b0;
    in_disp_op         = '0;
    in_disp_a_valid    = 1'b0;
    in_disp_a_value    = '0;
    in_disp_a_tag      = '0;
    in_disp_b_valid    = 1'b0;
    in_disp_b_value    = '0;
    in_disp_b_tag      = '0;
    in_disp_uses_nzcv  = 1'b0;
    in_disp_nzcv_valid = 1'b0;
    in_disp_nzcv       = '0;
    in_disp_nzcv_tag   = '0;
    in_disp_set_nzcv   = 1'b0;
    in_disp_dst_tag    = '0;
    in_bc_valid        = 1'b0;
    in_bc_tag          = '0;
    in_bc_value        = '0;
    in_bc_set_nzcv     = 1'b0;
    in_bc_nzcv         = '0;
    in_mispred         = 1'b0;
    in_alu_ready       = 1'b0;
    in_ls_ready        = 1'b0;
    error_count        = 0;
    check_count        = 0;
    test_count         = 0;
    test_fail_count    = 0;
    test_errors        = 0;
    test_open          = 1'b0;
    cases_done         = 1'b0;
    test_name          = "setup";
    foreach (sent_set_nzcv[i]) begin
      sent_set_nzcv[i] = 1'b0;
    end
    repeat (10) @(posedge in_clk);
    #1;
    in_rst_n = 1'b1;
    fd = $fopen("test/rs_cases.txt", "r");
    if (fd == 0) begin
      note_error("could not open test/rs_cases.txt");
    end else begin
      run_cases();
      $fclose(fd);
    end
    $display("tests %0d, failed tests %0d, checks %0d, errors %0d",
             test_count, test_fail_count, check_count, error_count);
    if (error_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
